// ==== mpfPkg.sv ====
// Shared widths, scoreboard sizing, response type code and vector typedefs
package mpfPkg;

    // ==================================================================
    //  Bus widths
    // ==================================================================

    // Width of the read response data bus and of the write request data
    localparam int DataBits = 32;

    // Request and response headers share one width on both channels
    localparam int HdrBits = 16;

    // Metadata sits in the low bits of every header
    // The AFU owns it on requests and expects it back on responses
    localparam int MdataBits = 8;

    // ==================================================================
    //  Write scoreboard sizing
    // ==================================================================

    // Number of write requests that may be outstanding at the host
    localparam int ScoreboardEntries = 16;

    // Slot index width, which must cover ScoreboardEntries
    // The index replaces the metadata on its way to the host, so it
    // must also fit inside MdataBits
    localparam int IdxBits = 4;

    // Almost-full goes high when fewer than this many slots are free
    // The margin covers requests the AFU already has in flight when it
    // first sees almost-full
    localparam int AlmFullThreshold = 4;

    // ==================================================================
    //  Response encoding
    // ==================================================================

    // Type code of a write completion, placed just above the metadata
    // field in a response header
    localparam logic [3:0] WrLineRsp = 4'h1;

    // ==================================================================
    //  Vector types
    // ==================================================================

    typedef logic [DataBits-1:0]  dataT;
    typedef logic [HdrBits-1:0]   hdrT;
    typedef logic [MdataBits-1:0] mdataT;
    typedef logic [IdxBits-1:0]   idxT;

endpackage

// ==== cciIf.sv ====
// Two-channel request and response interface with host and AFU modports
`timescale 1ns/1ps

interface cciIf;
    import mpfPkg::*;

    // Channel 0 requests, reads only
    hdrT  c0TxHdr;
    logic c0TxRdValid;

    // Channel 0 responses
    // Reads return data here, and write completions may arrive here too
    hdrT  c0RxHdr;
    dataT c0RxData;
    logic c0RxRdValid;
    logic c0RxWrValid;

    // Back-pressure for channel 0 requests
    logic c0TxAlmFull;

    // Channel 1 requests, writes only
    hdrT  c1TxHdr;
    dataT c1TxData;
    logic c1TxWrValid;

    // Channel 1 responses carry write completions only
    hdrT  c1RxHdr;
    logic c1RxWrValid;

    // Back-pressure for channel 1 requests
    logic c1TxAlmFull;

    // Seen from a block that sits in front of the host
    // It issues requests and takes responses and back-pressure
    modport toHost (
        output c0TxHdr, c0TxRdValid,
        output c1TxHdr, c1TxData, c1TxWrValid,
        input  c0RxHdr, c0RxData, c0RxRdValid, c0RxWrValid,
        input  c1RxHdr, c1RxWrValid,
        input  c0TxAlmFull, c1TxAlmFull
    );

    // Seen from a block that serves the AFU
    // It returns responses and back-pressure and takes requests
    modport toAfu (
        input  c0TxHdr, c0TxRdValid,
        input  c1TxHdr, c1TxData, c1TxWrValid,
        output c0RxHdr, c0RxData, c0RxRdValid, c0RxWrValid,
        output c1RxHdr, c1RxWrValid,
        output c0TxAlmFull, c1TxAlmFull
    );

endinterface

// ==== mpfScoreboard.sv ====
// In-order write scoreboard with out-of-order completions on two channels
`timescale 1ns/1ps

module mpfScoreboard (
    input  logic         clk,
    input  logic         rstN,

    // Allocation side, one new write per cycle at most
    input  logic         enq,
    input  mpfPkg::mdataT enqMeta,
    output mpfPkg::idxT  enqIdx,
    output logic         almFull,

    // Completions from the host, one per channel per cycle
    input  logic         cplValid0,
    input  logic         cplValid1,
    input  mpfPkg::idxT  cplIdx0,
    input  mpfPkg::idxT  cplIdx1,

    // In-order release of the oldest slot
    output logic         headReady0,
    output logic         headReady1,
    output mpfPkg::mdataT headMeta,
    input  logic         deq
);
    import mpfPkg::*;

    // ==================================================================
    //  Storage
    // ==================================================================

    // Original AFU metadata of each slot, restored on the response
    mdataT metaMem [ScoreboardEntries];

    // A set bit means the host has answered the slot
    logic [ScoreboardEntries-1:0] doneVec;

    // Channel the completion arrived on, 1 for channel 1
    // Only meaningful while the matching done bit is set
    logic [ScoreboardEntries-1:0] chanVec;

    // Oldest outstanding slot and next slot to allocate
    idxT head;
    idxT tail;

    // Number of allocated slots, one bit wider so a full buffer is seen
    logic [IdxBits:0] count;
    logic [IdxBits:0] freeSlots;
    logic             empty;

    // ==================================================================
    //  Pointers, occupancy and done bits
    // ==================================================================

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            doneVec <= '0;
        end
        else
        begin
            // Pointers wrap naturally since the depth is a power of two
            if (enq)
            begin
                tail <= tail + 1'b1;
            end
            if (deq)
            begin
                head <= head + 1'b1;
            end

            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // The released slot is free again from the next cycle
            if (deq)
            begin
                doneVec[head] <= 1'b0;
            end

            // The host names the slot by its index, in any order
            if (cplValid0)
            begin
                doneVec[cplIdx0] <= 1'b1;
            end
            if (cplValid1)
            begin
                doneVec[cplIdx1] <= 1'b1;
            end

            // A fresh allocation always starts out pending
            if (enq)
            begin
                doneVec[tail] <= 1'b0;
            end
        end
    end

    // ==================================================================
    //  Slot payload
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            metaMem[tail] <= enqMeta;
        end

        // Remember where each answer came from so the AFU sees it there
        if (cplValid0)
        begin
            chanVec[cplIdx0] <= 1'b0;
        end
        if (cplValid1)
        begin
            chanVec[cplIdx1] <= 1'b1;
        end
    end

    // ==================================================================
    //  Outputs
    // ==================================================================

    assign enqIdx = tail;

    // Free slots against the reserve kept for requests still in flight
    assign freeSlots = (IdxBits+1)'(ScoreboardEntries) - count;
    assign almFull   = freeSlots < (IdxBits+1)'(AlmFullThreshold);

    assign empty = (count == '0);

    // Only the head may leave, and only on the channel it was answered on
    assign headReady0 = !empty && doneVec[head] && !chanVec[head];
    assign headReady1 = !empty && doneVec[head] && chanVec[head];
    assign headMeta   = metaMem[head];

endmodule

// ==== mpfSortWriteRsp.sv ====
// Shim that returns write responses to the AFU in request order
`timescale 1ns/1ps

module mpfSortWriteRsp (
    input  logic clk,
    input  logic rstN,

    // Toward the host, where write answers come back unordered
    cciIf.toHost qlp,

    // Toward the AFU, which sees write answers in request order
    cciIf.toAfu  afu
);
    import mpfPkg::*;

    // ==================================================================
    //  Write scoreboard
    // ==================================================================

    idxT   sbEnqIdx;
    logic  sbAlmFull;
    logic  headReady0;
    logic  headReady1;
    mdataT headMeta;

    // Sorted write strobes toward the AFU
    logic wrValid0;
    logic wrValid1;
    logic wrDeq;

    // Response header for a released write
    hdrT wrRspHdr;

    // Metadata sits in the low header bits, and the host echoes the slot
    // index in the same place on its completions
    mpfScoreboard wrScoreboard (
        .clk,
        .rstN,
        .enq        (afu.c1TxWrValid),
        .enqMeta    (afu.c1TxHdr[MdataBits-1:0]),
        .enqIdx     (sbEnqIdx),
        .almFull    (sbAlmFull),
        .cplValid0  (qlp.c0RxWrValid),
        .cplValid1  (qlp.c1RxWrValid),
        .cplIdx0    (qlp.c0RxHdr[IdxBits-1:0]),
        .cplIdx1    (qlp.c1RxHdr[IdxBits-1:0]),
        .headReady0 (headReady0),
        .headReady1 (headReady1),
        .headMeta   (headMeta),
        .deq        (wrDeq)
    );

    // ==================================================================
    //  Back-pressure
    // ==================================================================

    // Both channels stop together so loads and stores keep their order
    // The scoreboard reserve absorbs writes issued before the AFU reacts
    assign afu.c0TxAlmFull = qlp.c0TxAlmFull || qlp.c1TxAlmFull || sbAlmFull;
    assign afu.c1TxAlmFull = qlp.c0TxAlmFull || qlp.c1TxAlmFull || sbAlmFull;

    // ==================================================================
    //  Channel 0, reads pass straight through
    // ==================================================================

    assign qlp.c0TxHdr     = afu.c0TxHdr;
    assign qlp.c0TxRdValid = afu.c0TxRdValid;

    assign afu.c0RxData    = qlp.c0RxData;
    assign afu.c0RxRdValid = qlp.c0RxRdValid;

    // A read response owns the channel, and the sorted write simply stays
    // at the head of the scoreboard until a free cycle comes along
    assign wrValid0 = headReady0 && !qlp.c0RxRdValid;
    assign afu.c0RxWrValid = wrValid0;
    assign afu.c0RxHdr = wrValid0 ? wrRspHdr : qlp.c0RxHdr;

    // ==================================================================
    //  Channel 1, writes carry the slot index to the host
    // ==================================================================

    // The original metadata waits in the scoreboard, so the index takes
    // its place and comes back on the completion
    assign qlp.c1TxHdr = afu.c1TxWrValid ?
                         {afu.c1TxHdr[HdrBits-1:MdataBits], mdataT'(sbEnqIdx)} :
                         afu.c1TxHdr;
    assign qlp.c1TxData    = afu.c1TxData;
    assign qlp.c1TxWrValid = afu.c1TxWrValid;

    assign wrValid1 = headReady1;
    assign afu.c1RxWrValid = wrValid1;
    assign afu.c1RxHdr = wrValid1 ? wrRspHdr : qlp.c1RxHdr;

    // ==================================================================
    //  Sorted response
    // ==================================================================

    // Type code above the restored metadata, zero above that
    assign wrRspHdr = hdrT'({WrLineRsp, headMeta});

    // At most one of the two is high, as the head has a single channel
    assign wrDeq = wrValid0 || wrValid1;

endmodule

// ==== mpfTop.sv ====
// Top level that maps plain host and AFU ports onto the sorting shim
`timescale 1ns/1ps

module mpfTop (
    input  logic          clk,
    input  logic          rstN,

    // Host side, requests out and unordered responses in
    output mpfPkg::hdrT   hostC0TxHdr,
    output logic          hostC0TxRdValid,
    input  mpfPkg::hdrT   hostC0RxHdr,
    input  mpfPkg::dataT  hostC0RxData,
    input  logic          hostC0RxRdValid,
    input  logic          hostC0RxWrValid,
    input  logic          hostC0TxAlmFull,
    output mpfPkg::hdrT   hostC1TxHdr,
    output mpfPkg::dataT  hostC1TxData,
    output logic          hostC1TxWrValid,
    input  mpfPkg::hdrT   hostC1RxHdr,
    input  logic          hostC1RxWrValid,
    input  logic          hostC1TxAlmFull,

    // AFU side, requests in and ordered responses out
    input  mpfPkg::hdrT   afuC0TxHdr,
    input  logic          afuC0TxRdValid,
    output mpfPkg::hdrT   afuC0RxHdr,
    output mpfPkg::dataT  afuC0RxData,
    output logic          afuC0RxRdValid,
    output logic          afuC0RxWrValid,
    output logic          afuC0TxAlmFull,
    input  mpfPkg::hdrT   afuC1TxHdr,
    input  mpfPkg::dataT  afuC1TxData,
    input  logic          afuC1TxWrValid,
    output mpfPkg::hdrT   afuC1RxHdr,
    output logic          afuC1RxWrValid,
    output logic          afuC1TxAlmFull
);

    cciIf hostBus ();
    cciIf afuBus ();

    // ==================================================================
    //  Host bus
    // ==================================================================

    assign hostC0TxHdr     = hostBus.c0TxHdr;
    assign hostC0TxRdValid = hostBus.c0TxRdValid;
    assign hostC1TxHdr     = hostBus.c1TxHdr;
    assign hostC1TxData    = hostBus.c1TxData;
    assign hostC1TxWrValid = hostBus.c1TxWrValid;

    assign hostBus.c0RxHdr     = hostC0RxHdr;
    assign hostBus.c0RxData    = hostC0RxData;
    assign hostBus.c0RxRdValid = hostC0RxRdValid;
    assign hostBus.c0RxWrValid = hostC0RxWrValid;
    assign hostBus.c0TxAlmFull = hostC0TxAlmFull;
    assign hostBus.c1RxHdr     = hostC1RxHdr;
    assign hostBus.c1RxWrValid = hostC1RxWrValid;
    assign hostBus.c1TxAlmFull = hostC1TxAlmFull;

    // ==================================================================
    //  AFU bus
    // ==================================================================

    assign afuBus.c0TxHdr     = afuC0TxHdr;
    assign afuBus.c0TxRdValid = afuC0TxRdValid;
    assign afuBus.c1TxHdr     = afuC1TxHdr;
    assign afuBus.c1TxData    = afuC1TxData;
    assign afuBus.c1TxWrValid = afuC1TxWrValid;

    assign afuC0RxHdr     = afuBus.c0RxHdr;
    assign afuC0RxData    = afuBus.c0RxData;
    assign afuC0RxRdValid = afuBus.c0RxRdValid;
    assign afuC0RxWrValid = afuBus.c0RxWrValid;
    assign afuC0TxAlmFull = afuBus.c0TxAlmFull;
    assign afuC1RxHdr     = afuBus.c1RxHdr;
    assign afuC1RxWrValid = afuBus.c1RxWrValid;
    assign afuC1TxAlmFull = afuBus.c1TxAlmFull;

    // The shim faces the host through qlp and the AFU through afu
    mpfSortWriteRsp sortWriteRsp (
        .clk,
        .rstN,
        .qlp (hostBus.toHost),
        .afu (afuBus.toAfu)
    );

endmodule

// ==== mpfSort_properties.sv ====
// Concurrent assertions on the write sorting shim and their bind statement
`timescale 1ns/1ps

module mpfSortProperties (
    input logic clk,
    input logic rstN,
    input logic rdValid,
    input logic wrReq,
    input logic wrValid0,
    input logic wrValid1,
    input logic almFull0,
    input logic almFull1
);

    // Number of assertion failures so far
    int assertFails = 0;

    // Writes requested by the AFU and not yet answered
    int openWrites;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            openWrites <= 0;
        end
        else
        begin
            openWrites <= openWrites + int'(wrReq) - int'(wrValid0 || wrValid1);
        end
    end

    // A read response owns channel 0 for its cycle
    noSharedChannel0: assert property (@(posedge clk) disable iff (!rstN)
        !(rdValid && wrValid0))
    else
    begin
        assertFails++;
        $error("channel 0 write response in the same cycle as a read response");
    end

    // An empty scoreboard and host almost-full held low give no back-pressure
    almFullLowAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!almFull0 && !almFull1))
    else
    begin
        assertFails++;
        $error("almost-full high in the first cycle after reset");
    end

    // Nothing can be released while no write is outstanding
    noRspWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        (openWrites == 0) |-> !(wrValid0 || wrValid1))
    else
    begin
        assertFails++;
        $error("write response while no write is outstanding");
    end

endmodule

bind mpfSortWriteRsp mpfSortProperties sortProps (
    .clk      (clk),
    .rstN     (rstN),
    .rdValid  (qlp.c0RxRdValid),
    .wrReq    (afu.c1TxWrValid),
    .wrValid0 (afu.c0RxWrValid),
    .wrValid1 (afu.c1RxWrValid),
    .almFull0 (afu.c0TxAlmFull),
    .almFull1 (afu.c1TxAlmFull)
);

// ==== mpfChecker.sv ====
// Checker that models in-order write release and compares the DUT ports with it
`timescale 1ns/1ps

module mpfChecker (
    input logic         clk,
    input logic         rstN,
    input mpfPkg::hdrT  hostC0TxHdr,
    input logic         hostC0TxRdValid,
    input mpfPkg::hdrT  hostC0RxHdr,
    input mpfPkg::dataT hostC0RxData,
    input logic         hostC0RxRdValid,
    input logic         hostC0RxWrValid,
    input logic         hostC0TxAlmFull,
    input mpfPkg::hdrT  hostC1TxHdr,
    input mpfPkg::dataT hostC1TxData,
    input logic         hostC1TxWrValid,
    input mpfPkg::hdrT  hostC1RxHdr,
    input logic         hostC1RxWrValid,
    input logic         hostC1TxAlmFull,
    input mpfPkg::hdrT  afuC0TxHdr,
    input logic         afuC0TxRdValid,
    input mpfPkg::hdrT  afuC0RxHdr,
    input mpfPkg::dataT afuC0RxData,
    input logic         afuC0RxRdValid,
    input logic         afuC0RxWrValid,
    input logic         afuC0TxAlmFull,
    input mpfPkg::hdrT  afuC1TxHdr,
    input mpfPkg::dataT afuC1TxData,
    input logic         afuC1TxWrValid,
    input mpfPkg::hdrT  afuC1RxHdr,
    input logic         afuC1RxWrValid,
    input logic         afuC1TxAlmFull
);
    import mpfPkg::*;

    // Expected writes in request order with the slot index above the original metadata
    logic [IdxBits+MdataBits-1:0] expQ [$];
    logic [IdxBits+MdataBits-1:0] entry;

    // Host completion seen per slot and the channel it used (1 for channel 1)
    logic [ScoreboardEntries-1:0] cplSeen = '0;
    logic [ScoreboardEntries-1:0] cplChan = '0;

    idxT  nextSlot = '0;
    int   outstanding = 0;
    int   checkCount = 0;
    int   errCount = 0;
    int   testErrs = 0;
    int   testNum = 0;
    logic expAf;
    hdrT  rspHdr;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errCount++;
            testErrs++;
            $display("FAIL time %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errCount++;
        testErrs++;
        $display("ERROR time %0t %s", $time, what);
    endtask

    function automatic int pendingCount();
        return expQ.size();
    endfunction

    task automatic endTest(input string name);
        testNum++;
        $display("Test %0d %s: %0d errors", testNum, name, testErrs);
        testErrs = 0;
    endtask

    task automatic finishRun();
        if (expQ.size() != 0)
        begin
            reportProblem($sformatf("%0d writes were never answered", expQ.size()));
        end
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
    endtask

    // ==================================================================
    //  Per-cycle comparison at mid-cycle where every port has settled
    // ==================================================================

    always @(negedge clk)
    begin
        if (rstN)
        begin
            // Back-pressure from either host channel or a short slot reserve
            expAf = hostC0TxAlmFull || hostC1TxAlmFull ||
                    (ScoreboardEntries - outstanding < AlmFullThreshold);
            checkValue("afuC0TxAlmFull", expAf, afuC0TxAlmFull);
            checkValue("afuC1TxAlmFull", expAf, afuC1TxAlmFull);

            // Reads go through untouched in both directions
            checkValue("hostC0TxRdValid", afuC0TxRdValid, hostC0TxRdValid);
            if (afuC0TxRdValid)
            begin
                checkValue("hostC0TxHdr", afuC0TxHdr, hostC0TxHdr);
            end
            checkValue("afuC0RxRdValid", hostC0RxRdValid, afuC0RxRdValid);
            if (hostC0RxRdValid)
            begin
                checkValue("afuC0RxHdr", hostC0RxHdr, afuC0RxHdr);
                checkValue("afuC0RxData", hostC0RxData, afuC0RxData);
                if (afuC0RxWrValid)
                begin
                    reportProblem("channel 0 write response shares a cycle with a read");
                end
            end

            // Released writes must follow request order exactly
            if (afuC0RxWrValid && afuC1RxWrValid)
            begin
                reportProblem("write responses on both channels in one cycle");
            end
            else if (afuC0RxWrValid || afuC1RxWrValid)
            begin
                if (expQ.size() == 0)
                begin
                    reportProblem("write response with no write outstanding");
                end
                else
                begin
                    entry = expQ.pop_front();
                    outstanding--;
                    rspHdr = afuC1RxWrValid ? afuC1RxHdr : afuC0RxHdr;
                    checkValue("write response header",
                               {{(HdrBits-MdataBits-4){1'b0}}, WrLineRsp,
                                entry[MdataBits-1:0]}, rspHdr);
                    if (!cplSeen[entry[IdxBits+MdataBits-1:MdataBits]])
                    begin
                        reportProblem("write response before the host completed the slot");
                    end
                    else
                    begin
                        checkValue("write response channel",
                                   cplChan[entry[IdxBits+MdataBits-1:MdataBits]],
                                   afuC1RxWrValid);
                    end
                    cplSeen[entry[IdxBits+MdataBits-1:MdataBits]] = 1'b0;
                end
            end

            // Writes reach the host with the next slot index as metadata
            checkValue("hostC1TxWrValid", afuC1TxWrValid, hostC1TxWrValid);
            if (afuC1TxWrValid)
            begin
                checkValue("hostC1TxHdr",
                           {afuC1TxHdr[HdrBits-1:MdataBits], mdataT'(nextSlot)}, hostC1TxHdr);
                checkValue("hostC1TxData", afuC1TxData, hostC1TxData);
                expQ.push_back({nextSlot, afuC1TxHdr[MdataBits-1:0]});
                nextSlot++;
                outstanding++;
                if (outstanding > ScoreboardEntries)
                begin
                    reportProblem("more writes outstanding than scoreboard slots");
                end
            end

            // Completions are recorded last since a response never shares their cycle
            if (hostC0RxWrValid)
            begin
                cplSeen[hostC0RxHdr[IdxBits-1:0]] = 1'b1;
                cplChan[hostC0RxHdr[IdxBits-1:0]] = 1'b0;
            end
            if (hostC1RxWrValid)
            begin
                cplSeen[hostC1RxHdr[IdxBits-1:0]] = 1'b1;
                cplChan[hostC1RxHdr[IdxBits-1:0]] = 1'b1;
            end
        end
    end

endmodule

// ==== mpfTb.sv ====
// Testbench top with clock, reset, LFSR, AFU stimulus, host model, watchdog, DUT and checker
`timescale 1ns/1ps

module mpfTb;
    import mpfPkg::*;

    localparam int CycleNs = 20;

    // Test lengths in cycles
    localparam int OrderCycles = 300;
    localparam int MixedCycles = 400;
    localparam int BurstCycles = 200;
    localparam int HostAfCycles = 200;
    localparam int FillCycles = 60;
    localparam int DrainCycles = 300;
    localparam int WatchdogCycles = OrderCycles + MixedCycles + BurstCycles +
                                    HostAfCycles + FillCycles + DrainCycles + 200;

    // Traffic mixes go from sparse writes through reads with writes to a write every cycle
    localparam int ModeWrites = 0;
    localparam int ModeMixed = 1;
    localparam int ModeFullWrites = 2;

    logic clk;
    logic rstN;
    hdrT  hostC0TxHdr, hostC0RxHdr, hostC1TxHdr, hostC1RxHdr;
    hdrT  afuC0TxHdr, afuC0RxHdr, afuC1TxHdr, afuC1RxHdr;
    dataT hostC0RxData, hostC1TxData, afuC0RxData, afuC1TxData;
    logic hostC0TxRdValid, hostC0RxRdValid, hostC0RxWrValid, hostC0TxAlmFull;
    logic hostC1TxWrValid, hostC1RxWrValid, hostC1TxAlmFull;
    logic afuC0TxRdValid, afuC0RxRdValid, afuC0RxWrValid, afuC0TxAlmFull;
    logic afuC1TxWrValid, afuC1RxWrValid, afuC1TxAlmFull;

    logic [31:0] lfsr = 32'h637e;
    int   cycle = 0;
    int   trafficMode = ModeWrites;
    int   drainWait;
    logic issueEnable = 1'b0;
    logic cplEnable = 1'b0;

    // Host model holds write slots awaiting completion and reads awaiting data
    idxT  pendingWr [$];
    hdrT  readHdrQ [$];
    int   readDueQ [$];

    mpfTop uut (.*);
    mpfChecker chk (.*);

    // Fibonacci LFSR with taps 32 22 2 1 that steps once for each bit handed out
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #(CycleNs/2) clk = ~clk;
    end

    initial
    begin
        #(WatchdogCycles * CycleNs);
        $display("Watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    // ==================================================================
    //  One cycle of AFU requests and host responses
    // ==================================================================

    task automatic driveCycle();
        logic [1:0] kind;
        logic afSeen;
        logic wantRd;
        logic wantWr;
        int   pick;
        @(posedge clk);
        #2;
        cycle++;
        afSeen = afuC0TxAlmFull || afuC1TxAlmFull;
        afuC0TxRdValid = 1'b0;
        afuC1TxWrValid = 1'b0;
        hostC0RxRdValid = 1'b0;
        hostC0RxWrValid = 1'b0;
        hostC1RxWrValid = 1'b0;

        kind = 2'(randBits(2));
        wantWr = (trafficMode == ModeFullWrites) || (kind == 2'd1) ||
                 (trafficMode == ModeWrites && kind == 2'd2);
        wantRd = (trafficMode == ModeMixed) && (kind == 2'd0 || kind == 2'd2);
        if (issueEnable && !afSeen && wantWr)
        begin
            afuC1TxWrValid = 1'b1;
            afuC1TxHdr = hdrT'(randBits(HdrBits));
            afuC1TxData = randBits(DataBits);
        end
        else if (issueEnable && !afSeen && wantRd)
        begin
            afuC0TxRdValid = 1'b1;
            afuC0TxHdr = hdrT'(randBits(HdrBits));
        end

        // Reads come back in issue order once each delay has passed
        if (readDueQ.size() > 0 && readDueQ[0] <= cycle)
        begin
            hostC0RxRdValid = 1'b1;
            hostC0RxHdr = readHdrQ.pop_front();
            hostC0RxData = dataT'(hostC0RxHdr);
            void'(readDueQ.pop_front());
        end

        // Any pending write may finish
        // Channel 0 carries it only when no read response holds that channel
        if (cplEnable && pendingWr.size() > 0 && randBits(1))
        begin
            pick = int'(randBits(4)) % pendingWr.size();
            if (randBits(1) || hostC0RxRdValid)
            begin
                hostC1RxWrValid = 1'b1;
                hostC1RxHdr = hdrT'(pendingWr[pick]);
            end
            else
            begin
                hostC0RxWrValid = 1'b1;
                hostC0RxHdr = hdrT'(pendingWr[pick]);
            end
            pendingWr.delete(pick);
        end
    endtask

    // Host takes requests mid-cycle once the DUT outputs have settled
    always @(negedge clk)
    begin
        if (rstN && hostC1TxWrValid)
        begin
            pendingWr.push_back(hostC1TxHdr[IdxBits-1:0]);
        end
        if (rstN && hostC0TxRdValid)
        begin
            readHdrQ.push_back(hostC0TxHdr);
            readDueQ.push_back(cycle + 1 + int'(randBits(3)));
        end
    end

    // ==================================================================
    //  Test sequence
    // ==================================================================

    initial
    begin
        rstN = 1'b0;
        {hostC0RxHdr, hostC1RxHdr, afuC0TxHdr, afuC1TxHdr} = '0;
        {hostC0RxData, afuC1TxData} = '0;
        {hostC0RxRdValid, hostC0RxWrValid, hostC1RxWrValid} = '0;
        {hostC0TxAlmFull, hostC1TxAlmFull, afuC0TxRdValid, afuC1TxWrValid} = '0;
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;

        issueEnable = 1'b1;
        cplEnable = 1'b1;
        repeat (OrderCycles) driveCycle();
        chk.endTest("write ordering");

        trafficMode = ModeMixed;
        repeat (MixedCycles) driveCycle();
        chk.endTest("reads mixed with writes");

        trafficMode = ModeFullWrites;
        repeat (BurstCycles) driveCycle();
        chk.endTest("back-to-back writes");

        // Host channel 0 back-pressure for a window in the middle
        trafficMode = ModeMixed;
        for (int i = 0; i < HostAfCycles; i++)
        begin
            driveCycle();
            hostC0TxAlmFull = (i >= 60 && i < 120);
        end
        hostC0TxAlmFull = 1'b0;
        chk.endTest("host almost-full");

        // Unanswered writes fill the scoreboard until the reserve stops the AFU
        // Completions then drain every slot
        trafficMode = ModeFullWrites;
        cplEnable = 1'b0;
        repeat (FillCycles) driveCycle();
        issueEnable = 1'b0;
        cplEnable = 1'b1;
        drainWait = 0;
        while ((chk.pendingCount() > 0 || pendingWr.size() > 0 || readHdrQ.size() > 0) &&
               drainWait < DrainCycles)
        begin
            driveCycle();
            drainWait++;
        end
        repeat (4) driveCycle();
        chk.endTest("scoreboard fill and drain");

        chk.finishRun();
        if (chk.errCount + uut.sortWriteRsp.sortProps.assertFails == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
mpfPkg.sv
cciIf.sv
mpfScoreboard.sv
mpfSortWriteRsp.sv
mpfTop.sv
mpfSort_properties.sv
mpfChecker.sv
mpfTb.sv
